/* files.f */
hdl/crop_pkg.sv
hdl/line_timer.sv
hdl/frame_timer.sv
hdl/crop_keys.sv
hdl/screen_status.sv
hdl/pixel_enable.sv
hdl/crop_blanker.sv
verification/video_source.sv
verification/crop_tb.sv

/* hdl/crop_blanker.sv */
`timescale 1ns/1ps

module crop_blanker
	import crop_pkg::*;
#(
	parameter int CNT_W = 12
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             hsync_n,
	input  logic             vsync_n,
	input  logic             hblank,
	input  logic             vblank,
	input  logic             field1,
	input  res_e             res,
	input  logic             scandoubler_off,
	input  logic             kms_level,
	input  logic [1:0]       kms_type,
	input  crop_key_e        kms_data,
	input  logic             preset_load,
	input  logic [CNT_W-1:0] preset_hbl_l,
	input  logic [CNT_W-1:0] preset_hbl_r,
	input  logic [CNT_W-1:0] preset_vbl_t,
	input  logic [CNT_W-1:0] preset_vbl_b,
	output logic             de,
	output logic             ce_pix,
	output logic [CNT_W-1:0] scr_hbl_l,
	output logic [CNT_W-1:0] scr_hbl_r,
	output logic [CNT_W-1:0] scr_vbl_t,
	output logic [CNT_W-1:0] scr_vbl_b,
	output logic [CNT_W-1:0] scr_hsize,
	output logic [CNT_W-1:0] scr_vsize,
	output res_e             scr_res,
	output logic [6:0]       scr_flg
);

	logic [CNT_W-1:0] hbl_l;
	logic [CNT_W-1:0] hbl_r;
	logic [CNT_W-1:0] vbl_t;
	logic [CNT_W-1:0] vbl_b;
	logic [CNT_W-1:0] hcnt;
	logic [CNT_W-1:0] hsize;
	logic [CNT_W-1:0] vsize;
	logic             hend_pulse;
	logic             hbl;
	logic             hsize_take;
	logic             vblank_src_end;

	crop_keys #(.CNT_W(CNT_W)) u_crop_keys (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.kms_level    (kms_level),
		.kms_type     (kms_type),
		.kms_data     (kms_data),
		.preset_load  (preset_load),
		.preset_hbl_l (preset_hbl_l),
		.preset_hbl_r (preset_hbl_r),
		.preset_vbl_t (preset_vbl_t),
		.preset_vbl_b (preset_vbl_b),
		.hbl_l        (hbl_l),
		.hbl_r        (hbl_r),
		.vbl_t        (vbl_t),
		.vbl_b        (vbl_b)
	);

	line_timer #(.CNT_W(CNT_W)) u_line_timer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.hsync_n    (hsync_n),
		.hblank     (hblank),
		.hbl_l      (hbl_l),
		.hbl_r      (hbl_r),
		.hsize_take (hsize_take),
		.hcnt       (hcnt),
		.hend_pulse (hend_pulse),
		.hbl        (hbl),
		.hsize      (hsize)
	);

	frame_timer #(.CNT_W(CNT_W)) u_frame_timer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.vsync_n        (vsync_n),
		.hsync_n        (hsync_n),
		.vblank         (vblank),
		.field1         (field1),
		.hbl            (hbl),
		.hcnt           (hcnt),
		.hend_pulse     (hend_pulse),
		.vbl_t          (vbl_t),
		.vbl_b          (vbl_b),
		.hsize_take     (hsize_take),
		.vblank_src_end (vblank_src_end),
		.vsize          (vsize),
		.de             (de)
	);

	screen_status #(.CNT_W(CNT_W)) u_screen_status (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.vblank_src_end (vblank_src_end),
		.hbl_l          (hbl_l),
		.hbl_r          (hbl_r),
		.vbl_t          (vbl_t),
		.vbl_b          (vbl_b),
		.hsize          (hsize),
		.vsize          (vsize),
		.res            (res),
		.scr_hbl_l      (scr_hbl_l),
		.scr_hbl_r      (scr_hbl_r),
		.scr_vbl_t      (scr_vbl_t),
		.scr_vbl_b      (scr_vbl_b),
		.scr_hsize      (scr_hsize),
		.scr_vsize      (scr_vsize),
		.scr_res        (scr_res),
		.scr_flg        (scr_flg)
	);

	pixel_enable u_pixel_enable (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.vsync_n         (vsync_n),
		.res             (res),
		.scandoubler_off (scandoubler_off),
		.ce_pix          (ce_pix)
	);

endmodule

/* hdl/crop_keys.sv */
`timescale 1ns/1ps

module crop_keys
	import crop_pkg::*;
#(
	parameter int CNT_W = 12
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             kms_level,
	input  logic [1:0]       kms_type,
	input  crop_key_e        kms_data,
	input  logic             preset_load,
	input  logic [CNT_W-1:0] preset_hbl_l,
	input  logic [CNT_W-1:0] preset_hbl_r,
	input  logic [CNT_W-1:0] preset_vbl_t,
	input  logic [CNT_W-1:0] preset_vbl_b,
	output logic [CNT_W-1:0] hbl_l,
	output logic [CNT_W-1:0] hbl_r,
	output logic [CNT_W-1:0] vbl_t,
	output logic [CNT_W-1:0] vbl_b
);

	logic kms_level_d;
	logic key_ev;
	logic alt; // either alt held

	// each new event toggles the level
	assign key_ev = (kms_level ^ kms_level_d) && (kms_type == KMS_TYPE_KEY);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			kms_level_d <= 1'b0;
			alt         <= 1'b0;
			hbl_l       <= '0;
			hbl_r       <= '0;
			vbl_t       <= '0;
			vbl_b       <= '0;
		end else begin
			kms_level_d <= kms_level;

			if (key_ev && (kms_data == key_alt_l || kms_data == key_alt_r))
				alt <= 1'b1;
			if (key_ev && (kms_data == key_alt_l_rel || kms_data == key_alt_r_rel))
				alt <= 1'b0;

			if (preset_load) begin
				hbl_l <= preset_hbl_l;
				hbl_r <= preset_hbl_r;
				vbl_t <= preset_vbl_t;
				vbl_b <= preset_vbl_b;
			end else if (key_ev) begin
				case (kms_data)
					key_clear: begin
						hbl_l <= '0;
						hbl_r <= '0;
						vbl_t <= '0;
						vbl_b <= '0;
					end
					key_up: begin
						if (alt) vbl_b <= vbl_b + CNT_W'(V_STEP);
						else     vbl_t <= vbl_t + CNT_W'(V_STEP);
					end
					key_down: begin
						if (alt) vbl_b <= vbl_b - CNT_W'(V_STEP);
						else     vbl_t <= vbl_t - CNT_W'(V_STEP);
					end
					key_left: begin
						if (alt) hbl_r <= hbl_r + CNT_W'(H_STEP);
						else     hbl_l <= hbl_l + CNT_W'(H_STEP);
					end
					key_right: begin
						if (alt) hbl_r <= hbl_r - CNT_W'(H_STEP);
						else     hbl_l <= hbl_l - CNT_W'(H_STEP);
					end
					default: ; // alt codes and unknown keys leave margins
				endcase
			end
		end
	end

	// preset always overrides a key in the same clock
	a_preset_wins: assert property (@(posedge clk_sys) disable iff (reset)
		preset_load |=> (hbl_l == $past(preset_hbl_l)) && (hbl_r == $past(preset_hbl_r))
			&& (vbl_t == $past(preset_vbl_t)) && (vbl_b == $past(preset_vbl_b)))
		else $error("preset margins not loaded");

endmodule

/* hdl/crop_pkg.sv */
package crop_pkg;

	// key codes as delivered by the keyboard path
	typedef enum logic [7:0] {
		key_clear     = 8'h41, // backspace
		key_up        = 8'h4c,
		key_down      = 8'h4d,
		key_right     = 8'h4e,
		key_left      = 8'h4f,
		key_alt_l     = 8'h64,
		key_alt_r     = 8'h65,
		key_alt_l_rel = 8'he4,
		key_alt_r_rel = 8'he5
	} crop_key_e;

	typedef enum logic [1:0] {
		res_lo  = 2'b00, // 7 MHz
		res_hi  = 2'b01, // 14 MHz
		res_shi = 2'b10  // 28 MHz
	} res_e;

	localparam logic [1:0] KMS_TYPE_KEY = 2'd3; // kms_type for keyboard data

	localparam int V_STEP = 1; // lines per key press
	localparam int H_STEP = 4; // pixels per key press

	localparam int H_FORCE_START  = 8; // pixel where forced hblank ends
	localparam int H_FORCE_MARGIN = 8; // forced hblank before line end
	localparam int V_FORCE_START  = 1; // line where forced vblank ends
	localparam int V_FORCE_MARGIN = 3; // forced vblank before frame end

	// crop edges lead the source edges by this much
	localparam int CROP_LEAD = 2;

endpackage

/* hdl/frame_timer.sv */
`timescale 1ns/1ps

module frame_timer
	import crop_pkg::*;
#(
	parameter int CNT_W = 12
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             vsync_n,
	input  logic             hsync_n,
	input  logic             vblank,
	input  logic             field1,
	input  logic             hbl,
	input  logic [CNT_W-1:0] hcnt,
	input  logic             hend_pulse,
	input  logic [CNT_W-1:0] vbl_t,
	input  logic [CNT_W-1:0] vbl_b,
	output logic             hsize_take,
	output logic             vblank_src_end,
	output logic [CNT_W-1:0] vsize,
	output logic             de
);

	logic             vsync_d;
	logic             hsync_d;
	logic             vblank_d;
	logic             hbl_d;
	logic             vblank_src_start;
	logic             hbl_fall;
	logic             svbl; // crop blank
	logic             fvbl; // forced blank
	logic             svbl_nx; // crop blank for the line now starting
	logic             fvbl_nx;
	logic [CNT_W-1:0] vcnt;
	logic [CNT_W-1:0] vend;
	logic [CNT_W-1:0] vsta;
	logic [CNT_W-1:0] vmax;
	logic [CNT_W-1:0] f1_vend;
	logic [CNT_W-1:0] f1_vsize; // odd field lines, waiting for the even field
	logic [CNT_W-1:0] vbl_t_q;
	logic [CNT_W-1:0] vbl_b_q;
	logic [CNT_W-1:0] crop_off;
	logic [CNT_W-1:0] crop_on;
	logic [CNT_W-1:0] force_on;

	assign vblank_src_end   = vblank_d & ~vblank;
	assign vblank_src_start = ~vblank_d & vblank;
	assign hbl_fall         = hbl_d & ~hbl;

	assign crop_off = vend + vbl_t_q - CNT_W'(CROP_LEAD - 1);
	assign crop_on  = vsta + vbl_b_q - CNT_W'(CROP_LEAD - 1);
	assign force_on = vmax - CNT_W'(V_FORCE_MARGIN);

	// vertical blank is decided once per line, where its active part starts
	always_comb begin
		svbl_nx = svbl;
		fvbl_nx = fvbl;
		if (hbl_fall) begin
			if (vcnt == crop_off) svbl_nx = 1'b0;
			if (vcnt == crop_on)  svbl_nx = 1'b1;

			if (vcnt == CNT_W'(V_FORCE_START)) fvbl_nx = 1'b0;
			if (vcnt == force_on)              fvbl_nx = 1'b1;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vsync_d    <= 1'b1;
			hsync_d    <= 1'b1;
			vblank_d   <= 1'b1;
			hbl_d      <= 1'b1;
			vcnt       <= '0;
			vend       <= '0;
			vsta       <= '0;
			vmax       <= '0;
			f1_vend    <= '0;
			f1_vsize   <= '0;
			vsize      <= '0;
			vbl_t_q    <= '0;
			vbl_b_q    <= '0;
			hsize_take <= 1'b0;
			svbl       <= 1'b1;
			fvbl       <= 1'b1;
			de         <= 1'b0;
		end else begin
			vsync_d  <= vsync_n;
			hsync_d  <= hsync_n;
			vblank_d <= vblank;
			hbl_d    <= hbl;

			if (~vsync_n)
				vcnt <= '0;
			else if (hsync_d & ~hsync_n)
				vcnt <= vcnt + CNT_W'(1);

			// margins only move at the top of the frame
			if (vcnt == '0 && hcnt == '0) begin
				vbl_t_q <= vbl_t;
				vbl_b_q <= vbl_b;
			end

			if (hend_pulse) hsize_take <= ~field1 & (vcnt == vsta + CNT_W'(1));

			if (~field1) begin
				if (vblank_src_end)     vend <= vcnt;
				if (vblank_src_start)   vsta <= vcnt;
				if (vsync_d & ~vsync_n) vmax <= vcnt;
				if (vblank_src_start) begin
					vsize    <= vcnt - vend + f1_vsize;
					f1_vsize <= '0;
				end
			end else begin
				if (vblank_src_end)   f1_vend  <= vcnt;
				if (vblank_src_start) f1_vsize <= vcnt - f1_vend;
			end

			svbl <= svbl_nx;
			fvbl <= fvbl_nx;

			de <= ~hbl & ~svbl_nx & ~fvbl_nx;
		end
	end

	// de opens only where the line blank ends, never inside a line
	a_de_at_line_start: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(de) |-> $past(hbl_fall))
		else $error("de opened inside a line");

endmodule

/* hdl/line_timer.sv */
`timescale 1ns/1ps

module line_timer
	import crop_pkg::*;
#(
	parameter int CNT_W = 12
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             hsync_n,
	input  logic             hblank,
	input  logic [CNT_W-1:0] hbl_l,
	input  logic [CNT_W-1:0] hbl_r,
	input  logic             hsize_take,
	output logic [CNT_W-1:0] hcnt,
	output logic             hend_pulse,
	output logic             hbl,
	output logic [CNT_W-1:0] hsize
);

	logic             hsync_d;
	logic             hblank_d;
	logic             hsta_pulse;
	logic             shbl; // crop blank
	logic             fhbl; // forced blank
	logic [CNT_W-1:0] hend;
	logic [CNT_W-1:0] hsta;
	logic [CNT_W-1:0] hmax;
	logic [CNT_W-1:0] crop_off;
	logic [CNT_W-1:0] crop_on;
	logic [CNT_W-1:0] force_on;

	assign hend_pulse = hblank_d & ~hblank; // active video starts
	assign hsta_pulse = ~hblank_d & hblank; // active video ends

	assign crop_off = hend + hbl_l - CNT_W'(CROP_LEAD);
	assign crop_on  = hsta + hbl_r - CNT_W'(CROP_LEAD);
	assign force_on = hmax - CNT_W'(H_FORCE_MARGIN);

	assign hbl = fhbl | shbl | ~hsync_n;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hsync_d  <= 1'b1;
			hblank_d <= 1'b1;
			hcnt     <= '0;
			hend     <= '0;
			hsta     <= '0;
			hmax     <= '0;
			shbl     <= 1'b1;
			fhbl     <= 1'b1;
			hsize    <= '0;
		end else begin
			hsync_d  <= hsync_n;
			hblank_d <= hblank;

			// position counts from the end of hsync
			if (hsync_n)
				hcnt <= hcnt + CNT_W'(1);
			else
				hcnt <= '0;

			if (hend_pulse)           hend <= hcnt;
			if (hsta_pulse)           hsta <= hcnt;
			if (hsync_d & ~hsync_n)   hmax <= hcnt; // full line length

			if (hcnt == crop_off) shbl <= 1'b0;
			if (hcnt == crop_on)  shbl <= 1'b1;

			if (hcnt == CNT_W'(H_FORCE_START)) fhbl <= 1'b0;
			if (hcnt == force_on)              fhbl <= 1'b1;

			// one reference line per frame
			if (hsta_pulse & hsize_take) hsize <= hcnt - hend;
		end
	end

	// width is taken inside a line, so it can't pass the line length
	a_hsize_in_line: assert property (@(posedge clk_sys) disable iff (reset)
		(hmax != '0) |-> (hsize <= hmax))
		else $error("hsize %0d beyond line length %0d", hsize, hmax);

endmodule

/* hdl/pixel_enable.sv */
`timescale 1ns/1ps

module pixel_enable
	import crop_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  logic vsync_n,
	input  res_e res,
	input  logic scandoubler_off,
	output logic ce_pix
);

	logic       vsync_d;
	logic [3:0] acc;
	logic [3:0] step;
	logic [3:0] step_sel;

	always_comb begin
		if (scandoubler_off) begin
			step_sel = 4'd8; // full rate without scandoubler
		end else begin
			case (res)
				res_lo:  step_sel = 4'd2;
				res_hi:  step_sel = 4'd4;
				default: step_sel = 4'd8;
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vsync_d <= 1'b1;
			acc     <= '0;
			step    <= 4'd2;
			ce_pix  <= 1'b0;
		end else begin
			vsync_d <= vsync_n;
			if (vsync_d & ~vsync_n) begin
				acc  <= '0; // phase locks to the frame
				step <= step_sel;
			end else begin
				acc <= acc + step;
			end
			ce_pix <= acc[3] & ~|acc[2:0];
		end
	end

	// fastest rate is every second clock
	a_ce_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		ce_pix |=> !ce_pix)
		else $error("ce_pix on back to back clocks, step %0d", step);

endmodule

/* hdl/screen_status.sv */
`timescale 1ns/1ps

module screen_status
	import crop_pkg::*;
#(
	parameter int CNT_W = 12
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             vblank_src_end,
	input  logic [CNT_W-1:0] hbl_l,
	input  logic [CNT_W-1:0] hbl_r,
	input  logic [CNT_W-1:0] vbl_t,
	input  logic [CNT_W-1:0] vbl_b,
	input  logic [CNT_W-1:0] hsize,
	input  logic [CNT_W-1:0] vsize,
	input  res_e             res,
	output logic [CNT_W-1:0] scr_hbl_l,
	output logic [CNT_W-1:0] scr_hbl_r,
	output logic [CNT_W-1:0] scr_vbl_t,
	output logic [CNT_W-1:0] scr_vbl_b,
	output logic [CNT_W-1:0] scr_hsize,
	output logic [CNT_W-1:0] scr_vsize,
	output res_e             scr_res,
	output logic [6:0]       scr_flg
);

	logic geom_changed;

	// compared against the last snapshot, not the live values
	assign geom_changed = (scr_res != res) || (scr_vsize != vsize) || (scr_hsize != hsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_res   <= res_lo;
			scr_flg   <= '0;
		end else if (vblank_src_end) begin
			scr_hbl_l <= hbl_l;
			scr_hbl_r <= hbl_r;
			scr_vbl_t <= vbl_t;
			scr_vbl_b <= vbl_b;
			scr_hsize <= hsize;
			scr_vsize <= vsize;
			scr_res   <= res;
			if (geom_changed) scr_flg <= scr_flg + 7'd1; // host polls for a change
		end
	end

endmodule

/* verification/crop_tb.sv */
`timescale 1ns/1ps

module crop_tb;
	import crop_pkg::*;

	localparam int CNT_W       = 12;
	localparam int LINE_LEN    = 200;
	localparam int ACT_W       = 128;
	localparam int FRAME_LINES = 40;
	localparam int ACT_L       = 24;
	localparam int TMO         = 2 * LINE_LEN * FRAME_LINES; // cycles per wait

	logic clk_sys = 1'b0;
	logic reset;
	logic hsync_n, vsync_n, hblank, vblank, field1;
	res_e res;
	res_e res_req;
	logic interlace;
	int   line_no;
	logic scandoubler_off;
	logic kms_level;
	logic [1:0] kms_type;
	crop_key_e kms_data;
	logic preset_load;
	logic [CNT_W-1:0] preset_hbl_l, preset_hbl_r, preset_vbl_t, preset_vbl_b;
	logic de, ce_pix;
	logic [CNT_W-1:0] scr_hbl_l, scr_hbl_r, scr_vbl_t, scr_vbl_b, scr_hsize, scr_vsize;
	res_e scr_res;
	logic [6:0] scr_flg;

	logic [31:0] lfsr = 32'h49d08676;
	logic        chk_stb;
	int          chk_exp, chk_act;
	string       chk_name;
	int          checks, errors, err_mark;
	int          n, m, v, flg0;

	always #20 clk_sys = ~clk_sys;

	video_source #(.LINE_LEN(LINE_LEN), .FRAME_LINES(FRAME_LINES), .ACT_LINES(ACT_L)) u_src (
		.clk_sys(clk_sys), .reset(reset), .interlace(interlace), .res_req(res_req),
		.hsync_n(hsync_n), .vsync_n(vsync_n), .hblank(hblank), .vblank(vblank),
		.field1(field1), .res(res), .line_no(line_no)
	);

	crop_blanker #(.CNT_W(CNT_W)) u_crop_blanker (
		.clk_sys(clk_sys), .reset(reset), .hsync_n(hsync_n), .vsync_n(vsync_n),
		.hblank(hblank), .vblank(vblank), .field1(field1), .res(res),
		.scandoubler_off(scandoubler_off), .kms_level(kms_level), .kms_type(kms_type),
		.kms_data(kms_data), .preset_load(preset_load), .preset_hbl_l(preset_hbl_l),
		.preset_hbl_r(preset_hbl_r), .preset_vbl_t(preset_vbl_t),
		.preset_vbl_b(preset_vbl_b), .de(de), .ce_pix(ce_pix), .scr_hbl_l(scr_hbl_l),
		.scr_hbl_r(scr_hbl_r), .scr_vbl_t(scr_vbl_t), .scr_vbl_b(scr_vbl_b),
		.scr_hsize(scr_hsize), .scr_vsize(scr_vsize), .scr_res(scr_res), .scr_flg(scr_flg)
	);

	a_value: assert property (@(posedge clk_sys) chk_stb |-> chk_exp == chk_act)
		else begin
			$display("ERR %s expected %0d actual %0d", chk_name, chk_exp, chk_act);
			errors++;
		end

	a_ce_gap: assert property (@(posedge clk_sys) disable iff (reset) ce_pix |=> !ce_pix)
		else begin
			$display("ce_pix fired on two clocks in a row");
			errors++;
		end

	task automatic check_value(input string name, input int exp, input int act);
		@(posedge clk_sys);
		chk_name <= name;
		chk_exp  <= exp;
		chk_act  <= act;
		chk_stb  <= 1'b1;
		@(posedge clk_sys); // assertion samples here
		chk_stb  <= 1'b0;
		@(posedge clk_sys);
		checks++;
	endtask

	task automatic end_test(input string name);
		$display("test %s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	endtask

	task automatic abort_run(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
		finish_run();
	endtask

	// one bit of the Galois register per step
	function automatic int get_bits(input int width);
		int val;
		val = 0;
		for (int i = 0; i < width; i++) begin
			val = (val << 1) | lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic wait_vsync();
		int t;
		t = 0;
		while (vsync_n !== 1'b1) begin
			@(posedge clk_sys);
			t++;
			if (t > TMO) abort_run("vsync end");
		end
		t = 0;
		while (vsync_n !== 1'b0) begin
			@(posedge clk_sys);
			t++;
			if (t > TMO) abort_run("vsync start");
		end
	endtask

	task automatic wait_frames(input int cnt);
		repeat (cnt) wait_vsync();
	endtask

	task automatic wait_line(input int l);
		int t;
		t = 0;
		while (line_no == l) begin
			@(posedge clk_sys);
			t++;
			if (t > TMO) abort_run("line change");
		end
		t = 0;
		while (line_no != l) begin
			@(posedge clk_sys);
			t++;
			if (t > TMO) abort_run("mid-frame line");
		end
	endtask

	task automatic press_key(input crop_key_e k);
		@(posedge clk_sys);
		kms_type  <= KMS_TYPE_KEY;
		kms_data  <= k;
		kms_level <= ~kms_level; // level toggle marks the event
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic count_de_line(output int cnt);
		cnt = 0;
		repeat (LINE_LEN) begin
			@(posedge clk_sys);
			if (de) cnt++;
		end
	endtask

	task automatic count_de_lines(output int lines);
		int c;
		lines = 0;
		wait_vsync();
		repeat (FRAME_LINES) begin
			count_de_line(c);
			if (c > 0) lines++;
		end
	endtask

	task automatic count_ce(input res_e r, input logic sd_off, input int exp, input string nm);
		int c;
		@(posedge clk_sys);
		res_req         <= r;
		scandoubler_off <= sd_off;
		wait_frames(2);
		c = 0;
		repeat (64) begin
			@(posedge clk_sys);
			if (ce_pix) c++;
		end
		check_value(nm, exp, c);
	endtask

	initial begin
		reset = 1'b1;
		interlace = 1'b0;
		res_req = res_lo;
		scandoubler_off = 1'b0;
		kms_level = 1'b0;
		kms_type = 2'd0;
		kms_data = key_up;
		preset_load = 1'b0;
		preset_hbl_l = '0;
		preset_hbl_r = '0;
		preset_vbl_t = '0;
		preset_vbl_b = '0;
		chk_stb = 1'b0;
		chk_exp = 0;
		chk_act = 0;
		checks = 0;
		errors = 0;
		err_mark = 0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		wait_frames(4);
		check_value("measure_hsize", ACT_W, scr_hsize);
		check_value("measure_vsize", ACT_L, scr_vsize);
		end_test("measurement");

		n = get_bits(2);
		m = get_bits(2);
		repeat (n) press_key(key_left);
		press_key(key_alt_l);
		repeat (m) press_key(key_left);
		press_key(key_alt_l_rel);
		wait_frames(2);
		check_value("hcrop_left", 4 * n, scr_hbl_l);
		check_value("hcrop_right", 4 * m, scr_hbl_r);
		wait_line(FRAME_LINES / 2);
		count_de_line(v);
		check_value("hcrop_de_width", ACT_W - 4 * n + 4 * m, v);
		end_test("horizontal_crop");

		n = get_bits(2);
		m = get_bits(2);
		repeat (n) press_key(key_up);
		wait_frames(2);
		check_value("vcrop_top", n, scr_vbl_t);
		check_value("vcrop_bottom_kept", 0, scr_vbl_b);
		press_key(key_alt_r);
		repeat (m) press_key(key_up);
		press_key(key_alt_r_rel);
		wait_frames(2);
		check_value("vcrop_top_kept", n, scr_vbl_t);
		check_value("vcrop_bottom", m, scr_vbl_b);
		count_de_lines(v);
		check_value("vcrop_de_lines", ACT_L - n + m, v);
		end_test("vertical_crop");

		press_key(key_clear);
		wait_frames(2);
		check_value("clear_hbl_l", 0, scr_hbl_l);
		check_value("clear_hbl_r", 0, scr_hbl_r);
		check_value("clear_vbl_t", 0, scr_vbl_t);
		check_value("clear_vbl_b", 0, scr_vbl_b);
		@(posedge clk_sys);
		v = get_bits(12);
		preset_hbl_l <= v;
		v = get_bits(12);
		preset_hbl_r <= v;
		v = get_bits(12);
		preset_vbl_t <= v;
		v = get_bits(12);
		preset_vbl_b <= v;
		preset_load  <= 1'b1;
		@(posedge clk_sys);
		preset_load  <= 1'b0;
		wait_frames(2);
		check_value("preset_hbl_l", preset_hbl_l, scr_hbl_l);
		check_value("preset_hbl_r", preset_hbl_r, scr_hbl_r);
		check_value("preset_vbl_t", preset_vbl_t, scr_vbl_t);
		check_value("preset_vbl_b", preset_vbl_b, scr_vbl_b);
		press_key(key_clear);
		end_test("clear_preset");

		wait_frames(2);
		flg0 = scr_flg;
		@(posedge clk_sys);
		res_req <= res_hi;
		wait_frames(2);
		check_value("flag_on_change", (flg0 + 1) % 128, scr_flg);
		check_value("flag_res", res_hi, scr_res);
		flg0 = scr_flg;
		wait_frames(2);
		check_value("flag_steady", flg0, scr_flg);
		end_test("change_flag");

		count_ce(res_lo, 1'b0, 8, "ce_res_lo");
		count_ce(res_hi, 1'b0, 16, "ce_res_hi");
		count_ce(res_shi, 1'b0, 32, "ce_res_shi");
		count_ce(res_lo, 1'b1, 32, "ce_sd_off");
		end_test("pixel_enable");

		@(posedge clk_sys);
		scandoubler_off <= 1'b0;
		interlace       <= 1'b1;
		wait_frames(6);
		check_value("interlace_hsize", ACT_W, scr_hsize);
		check_value("interlace_vsize", 2 * ACT_L, scr_vsize);
		end_test("interlace");

		finish_run();
	end

endmodule

/* verification/video_source.sv */
`timescale 1ns/1ps

module video_source
	import crop_pkg::*;
#(
	parameter int   LINE_LEN    = 200,
	parameter int   H_SYNC      = 4,
	parameter int   ACT_START   = 40,
	parameter int   ACT_END     = 168,
	parameter int   FRAME_LINES = 40,
	parameter int   V_ACT_START = 6,
	parameter int   ACT_LINES   = 24,
	parameter res_e RES         = res_lo
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic interlace, // taken at frame start
	input  res_e res_req,   // taken at frame start
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank,
	output logic vblank,
	output logic field1,
	output res_e res,
	output int   line_no
);

	int h;
	int line_no_q;

	assign line_no = line_no_q;

	assign hsync_n = !(h < H_SYNC);
	assign hblank  = !(h >= ACT_START && h < ACT_END); // toggles on every line
	assign vsync_n = !(line_no_q == 0);
	assign vblank  = !(line_no_q >= V_ACT_START && line_no_q < V_ACT_START + ACT_LINES);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			h         <= 0;
			line_no_q <= 0;
			field1    <= 1'b0;
			res       <= RES;
		end else if (h == LINE_LEN - 1) begin
			h <= 0;
			if (line_no_q == FRAME_LINES - 1) begin
				line_no_q <= 0;
				field1    <= interlace & ~field1; // odd and even fields alternate
				res       <= res_req;
			end else begin
				line_no_q <= line_no_q + 1;
			end
		end else begin
			h <= h + 1;
		end
	end

endmodule
